/* bounding_box.sv */
`default_nettype none

module bounding_box (
    input wire raster_pkg::triangle_t triangle,
    output raster_pkg::bbox_t box,
    output logic box_valid
);
    import raster_pkg::*;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    coord_t raw_min_x;
    coord_t raw_max_x;
    coord_t raw_min_y;
    coord_t raw_max_y;
    coord_t clip_min_x;
    coord_t clip_max_x;
    coord_t clip_min_y;
    coord_t clip_max_y;

    assign raw_min_x = min3(triangle.v0.x, triangle.v1.x, triangle.v2.x);
    assign raw_max_x = max3(triangle.v0.x, triangle.v1.x, triangle.v2.x);
    assign raw_min_y = min3(triangle.v0.y, triangle.v1.y, triangle.v2.y);
    assign raw_max_y = max3(triangle.v0.y, triangle.v1.y, triangle.v2.y);

    // Clip to the tile
    assign clip_min_x = (raw_min_x < 0) ? '0 : raw_min_x;
    assign clip_max_x = (raw_max_x > TILE_X_MAX) ? TILE_X_MAX : raw_max_x;
    assign clip_min_y = (raw_min_y < 0) ? '0 : raw_min_y;
    assign clip_max_y = (raw_max_y > TILE_Y_MAX) ? TILE_Y_MAX : raw_max_y;

    assign box.min_x = clip_min_x;
    assign box.max_x = clip_max_x;
    assign box.min_y = clip_min_y;
    assign box.max_y = clip_max_y;

    // A box entirely off one side ends up inverted after clipping
    assign box_valid = (clip_min_x <= clip_max_x) && (clip_min_y <= clip_max_y);

endmodule

`default_nettype wire

/* depth_buffer.sv */
`default_nettype none

module depth_buffer (
    input wire clk,
    input wire rst,
    input wire clear,
    input wire raster_pkg::fragment_t frag,
    input wire frag_valid,
    input wire raster_pkg::fb_addr_t rd_addr,
    output raster_pkg::depth_t rd_depth
);
    import raster_pkg::*;

    depth_t mem [FB_WORDS];
    logic nearer;

    // Smaller depth is closer to the viewer
    assign nearer = frag.depth < mem[frag.addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < FB_WORDS; i++) begin
                mem[i] <= DEPTH_FAR;
            end
        end else if (clear) begin
            for (int i = 0; i < FB_WORDS; i++) begin
                mem[i] <= DEPTH_FAR;
            end
        end else if (frag_valid && nearer) begin
            mem[frag.addr] <= frag.depth;
        end
    end

    // Host read port
    always_ff @(posedge clk) begin
        rd_depth <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* raster_pkg.sv */
`default_nettype none

package raster_pkg;

    // Tile geometry
    localparam int TILE_W = 32;
    localparam int TILE_H = 16;
    localparam int FB_WORDS = TILE_W * TILE_H;

    // Fixed point
    localparam int RECIP_FRAC = 12;
    localparam int RECIP_W = 12;
    localparam int DIV_W = 16;
    localparam int WEIGHT_W = 32;
    localparam int ZACC_W = 48;

    typedef logic signed [15:0] coord_t;
    typedef logic [15:0] depth_t;
    typedef logic [8:0] fb_addr_t;
    typedef logic [RECIP_W-1:0] recip_t;
    typedef logic [DIV_W-1:0] div_word_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [ZACC_W-1:0] zacc_t;
    typedef logic [3:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

    localparam coord_t TILE_X_MAX = coord_t'(TILE_W - 1);
    localparam coord_t TILE_Y_MAX = coord_t'(TILE_H - 1);
    localparam depth_t DEPTH_FAR = '1;
    localparam div_word_t DIV_DIVIDEND = div_word_t'(1 << RECIP_FRAC);

    // Register map
    localparam reg_addr_t REG_V0X = 4'd0;
    localparam reg_addr_t REG_V0Y = 4'd1;
    localparam reg_addr_t REG_V0Z = 4'd2;
    localparam reg_addr_t REG_V1X = 4'd3;
    localparam reg_addr_t REG_V1Y = 4'd4;
    localparam reg_addr_t REG_V1Z = 4'd5;
    localparam reg_addr_t REG_V2X = 4'd6;
    localparam reg_addr_t REG_V2Y = 4'd7;
    localparam reg_addr_t REG_V2Z = 4'd8;
    localparam reg_addr_t REG_CMD = 4'd9;
    localparam int CMD_START = 0;
    localparam int CMD_CLEAR = 1;

    typedef struct packed {
        coord_t x;
        coord_t y;
        depth_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        coord_t min_x;
        coord_t max_x;
        coord_t min_y;
        coord_t max_y;
    } bbox_t;

    typedef struct packed {
        fb_addr_t addr;
        depth_t depth;
    } fragment_t;

endpackage

`default_nettype wire

/* raster_regs.sv */
`default_nettype none

module raster_regs (
    input wire clk,
    input wire rst,
    input wire cfg_we,
    input wire raster_pkg::reg_addr_t cfg_addr,
    input wire raster_pkg::reg_data_t cfg_data,
    output raster_pkg::triangle_t triangle,
    output logic start,
    output logic clear
);
    import raster_pkg::*;

    logic cmd_write;

    assign cmd_write = cfg_we && (cfg_addr == REG_CMD);

    // Command bits become single-cycle strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start <= 1'b0;
            clear <= 1'b0;
        end else begin
            start <= cmd_write && cfg_data[CMD_START];
            clear <= cmd_write && cfg_data[CMD_CLEAR];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            triangle <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                REG_V0X: triangle.v0.x <= coord_t'(cfg_data);
                REG_V0Y: triangle.v0.y <= coord_t'(cfg_data);
                REG_V0Z: triangle.v0.z <= depth_t'(cfg_data);
                REG_V1X: triangle.v1.x <= coord_t'(cfg_data);
                REG_V1Y: triangle.v1.y <= coord_t'(cfg_data);
                REG_V1Z: triangle.v1.z <= depth_t'(cfg_data);
                REG_V2X: triangle.v2.x <= coord_t'(cfg_data);
                REG_V2Y: triangle.v2.y <= coord_t'(cfg_data);
                REG_V2Z: triangle.v2.z <= depth_t'(cfg_data);
                default: begin
                    // REG_CMD and unmapped addresses leave the vertices alone
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* raster_tb.sv */
`default_nettype none

module raster_tb;
    import raster_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RAND_PAIRS = 12;
    localparam int NUM_TRIANGLES = 5 + 2 * RAND_PAIRS;
    localparam int NUM_READBACKS = 5 + 2 * RAND_PAIRS;
    localparam int STEP_CYCLES = 600 + 40;
    // A draw or a full readback each fit in one step
    localparam int WATCHDOG_CYCLES = (NUM_TRIANGLES + NUM_READBACKS) * STEP_CYCLES;
    // Start strobe to done for a full-tile box: VERIFY, INIT, 16 divider cycles,
    // WEIGHTS, ZINIT, one cycle per pixel, then FINISH
    localparam int FULL_TILE_DONE = 2 + 16 + 2 + FB_WORDS + 1;

    logic clk;
    logic rst;
    logic cfg_we;
    reg_addr_t cfg_addr;
    reg_data_t cfg_data;
    fb_addr_t rd_addr;
    depth_t rd_depth;
    logic busy;
    logic done;

    int errors;
    int pixel_checks;
    int busy_rises;
    logic busy_q;

    // Current triangle and the expected buffer contents
    int tx [3];
    int ty [3];
    int tz [3];
    real model_z [FB_WORDS];
    bit model_hit [FB_WORDS];

    raster_top DUT (
        .clk(clk),
        .rst(rst),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .rd_addr(rd_addr),
        .rd_depth(rd_depth),
        .busy(busy),
        .done(done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic void report_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endfunction

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else report_error("done lasted more than one cycle");
    assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else report_error("busy still high while done pulses");
    assert property (@(posedge clk) disable iff (rst) busy |=> (busy || done))
        else report_error("busy fell without a done pulse");
    assert property (@(posedge clk) disable iff (rst) (DUT.start && !busy && !done) |=> busy)
        else report_error("busy did not rise in the cycle after start");
    assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> $past(DUT.start))
        else report_error("busy rose without a start strobe");

    // Count busy rises where the level is stable
    always @(negedge clk) begin
        busy_q <= busy;
        if (!rst && busy && !busy_q) begin
            busy_rises++;
        end
    end

    function automatic int edge_val(input int ax, input int ay, input int bx, input int by,
                                    input int px, input int py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic void model_clear();
        for (int i = 0; i < FB_WORDS; i++) begin
            model_z[i] = 65535.0;
            model_hit[i] = 1'b0;
        end
    endfunction

    // Ideal depth from barycentric weights, nearer value wins
    function automatic void model_draw();
        int area;
        int w0;
        int w1;
        int w2;
        int idx;
        real zi;
        area = edge_val(tx[0], ty[0], tx[1], ty[1], tx[2], ty[2]);
        if (area > 0) begin
            for (int py = 0; py < TILE_H; py++) begin
                for (int px = 0; px < TILE_W; px++) begin
                    w0 = edge_val(tx[1], ty[1], tx[2], ty[2], px, py);
                    w1 = edge_val(tx[2], ty[2], tx[0], ty[0], px, py);
                    w2 = edge_val(tx[0], ty[0], tx[1], ty[1], px, py);
                    idx = py * TILE_W + px;
                    if (w0 > 0 && w1 > 0 && w2 > 0) begin
                        zi = (real'(w0) * tz[0] + real'(w1) * tz[1] + real'(w2) * tz[2])
                             / real'(area);
                        if (!model_hit[idx] || zi < model_z[idx]) begin
                            model_z[idx] = zi;
                            model_hit[idx] = 1'b1;
                        end
                    end
                end
            end
        end
    endfunction

    function automatic void set_vertex(input int k, input int x, input int y, input int z);
        tx[k] = x;
        ty[k] = y;
        tz[k] = z;
    endfunction

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        @(negedge clk);
        cfg_we = 1'b1;
        cfg_addr = a;
        cfg_data = d;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic load_triangle();
        for (int k = 0; k < 3; k++) begin
            write_reg(reg_addr_t'(3 * k), reg_data_t'(tx[k]));
            write_reg(reg_addr_t'(3 * k + 1), reg_data_t'(ty[k]));
            write_reg(reg_addr_t'(3 * k + 2), reg_data_t'(tz[k]));
        end
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!done && cycles < STEP_CYCLES);
        if (!done) begin
            errors++;
            $display("Timeout: no done pulse within %0d cycles of start", STEP_CYCLES);
        end
    endtask

    task automatic clear_buffer();
        write_reg(REG_CMD, reg_data_t'(1 << CMD_CLEAR));
        @(negedge clk);
        model_clear();
    endtask

    task automatic draw_triangle(input bit reject);
        int cycles;
        load_triangle();
        write_reg(REG_CMD, reg_data_t'(1 << CMD_START));
        wait_done(cycles);
        if (reject) begin
            assert (cycles <= 3)
                else report_error($sformatf("rejected triangle took %0d cycles", cycles));
        end
        model_draw();
    endtask

    // A second start lands while the first draw is running
    task automatic draw_with_extra_start();
        int cycles;
        int rises;
        rises = busy_rises;
        load_triangle();
        write_reg(REG_CMD, reg_data_t'(1 << CMD_START));
        write_reg(REG_CMD, reg_data_t'(1 << CMD_START));
        wait_done(cycles);
        // The second write adds two cycles before the count begins
        assert (cycles + 2 == FULL_TILE_DONE)
            else report_error($sformatf("done came %0d cycles after start, expected %0d",
                                        cycles + 2, FULL_TILE_DONE));
        repeat (10) @(negedge clk);
        assert (busy_rises == rises + 1)
            else report_error($sformatf("busy rose %0d times for one draw", busy_rises - rises));
        model_draw();
    endtask

    task automatic check_buffer(input string what);
        depth_t got;
        real diff;
        int idx;
        for (int i = 0; i <= FB_WORDS; i++) begin
            @(negedge clk);
            if (i > 0) begin
                idx = i - 1;
                got = rd_depth;
                pixel_checks++;
                if (model_hit[idx]) begin
                    diff = real'(got) - model_z[idx];
                    assert (got != DEPTH_FAR && diff <= 2.0 && diff >= -2.0)
                        else report_error($sformatf("%s: pixel (%0d,%0d) holds %0d, expected %0.2f",
                                          what, idx % TILE_W, idx / TILE_W, got, model_z[idx]));
                end else begin
                    assert (got == DEPTH_FAR)
                        else report_error($sformatf("%s: pixel (%0d,%0d) holds %0d, expected far",
                                          what, idx % TILE_W, idx / TILE_W, got));
                end
            end
            if (i < FB_WORDS) begin
                rd_addr = fb_addr_t'(i);
            end
        end
    endtask

    task automatic random_triangle();
        int area;
        int span;
        int base;
        int t;
        do begin
            for (int k = 0; k < 3; k++) begin
                tx[k] = int'($urandom_range(45, 0)) - 7;
                ty[k] = int'($urandom_range(25, 0)) - 5;
            end
            area = edge_val(tx[0], ty[0], tx[1], ty[1], tx[2], ty[2]);
        end while (area == 0);
        // Swap two vertices to get the winding that is drawn
        if (area < 0) begin
            t = tx[1];
            tx[1] = tx[2];
            tx[2] = t;
            t = ty[1];
            ty[1] = ty[2];
            ty[2] = t;
            area = -area;
        end
        // Depth spread kept small enough for the 12-bit reciprocal
        span = 6000 / area;
        if (span > 3000) begin
            span = 3000;
        end
        base = int'($urandom_range(60000, 4000));
        tz[0] = base;
        tz[1] = base + int'($urandom_range(2 * span, 0)) - span;
        tz[2] = base + int'($urandom_range(2 * span, 0)) - span;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        rd_addr = '0;
        busy_q = 1'b0;
        errors = 0;
        pixel_checks = 0;
        busy_rises = 0;
        void'($urandom(32'h01f1_442e));
        model_clear();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!busy && !done && !DUT.start && !DUT.clear && !DUT.frag_valid && !DUT.div_start)
            else report_error("control signals not low after reset");

        set_vertex(0, 2, 1, 20000);
        set_vertex(1, 4, 14, 20010);
        set_vertex(2, 28, 3, 20016);
        draw_triangle(1'b0);
        check_buffer("triangle A");

        // Box off the tile, then A with reversed winding
        set_vertex(0, 40, 2, 1000);
        set_vertex(1, 45, 10, 1000);
        set_vertex(2, 50, 3, 1000);
        draw_triangle(1'b1);
        set_vertex(0, 2, 1, 100);
        set_vertex(1, 28, 3, 100);
        set_vertex(2, 4, 14, 100);
        draw_triangle(1'b1);
        check_buffer("rejected triangles");

        set_vertex(0, 10, 4, 19990);
        set_vertex(1, 12, 15, 20015);
        set_vertex(2, 30, 8, 20005);
        draw_triangle(1'b0);
        check_buffer("overlap of A and B");

        clear_buffer();
        check_buffer("after clear");

        set_vertex(0, 0, 0, 300);
        set_vertex(1, 0, 15, 310);
        set_vertex(2, 31, 0, 308);
        draw_with_extra_start();
        check_buffer("start while busy");

        for (int n = 0; n < RAND_PAIRS; n++) begin
            clear_buffer();
            random_triangle();
            draw_triangle(1'b0);
            check_buffer("random first");
            random_triangle();
            draw_triangle(1'b0);
            check_buffer("random overlap");
        end

        $display("Errors: %0d, pixel checks: %0d", errors, pixel_checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* raster_top.f */
raster_pkg.sv
raster_regs.sv
bounding_box.sv
reciprocal_divider.sv
rasterizer.sv
depth_buffer.sv
raster_top.sv
raster_tb.sv

/* raster_top.sv */
`default_nettype none

module raster_top (
    input wire clk,
    input wire rst,
    input wire cfg_we,
    input wire raster_pkg::reg_addr_t cfg_addr,
    input wire raster_pkg::reg_data_t cfg_data,
    input wire raster_pkg::fb_addr_t rd_addr,
    output raster_pkg::depth_t rd_depth,
    output logic busy,
    output logic done
);
    import raster_pkg::*;

    triangle_t triangle;
    bbox_t box;
    logic box_valid;
    logic start;
    logic clear;
    logic div_start;
    logic div_done;
    coord_t area;
    recip_t recip;
    fragment_t frag;
    logic frag_valid;

    raster_regs u_regs (
        .clk(clk),
        .rst(rst),
        .cfg_we(cfg_we),
        .cfg_addr(cfg_addr),
        .cfg_data(cfg_data),
        .triangle(triangle),
        .start(start),
        .clear(clear)
    );

    bounding_box u_bbox (
        .triangle(triangle),
        .box(box),
        .box_valid(box_valid)
    );

    reciprocal_divider u_div (
        .clk(clk),
        .rst(rst),
        .div_start(div_start),
        .area(area),
        .recip(recip),
        .div_done(div_done)
    );

    rasterizer u_raster (
        .clk(clk),
        .rst(rst),
        .start(start),
        .triangle(triangle),
        .box(box),
        .box_valid(box_valid),
        .recip(recip),
        .div_done(div_done),
        .div_start(div_start),
        .area(area),
        .frag(frag),
        .frag_valid(frag_valid),
        .busy(busy),
        .done(done)
    );

    depth_buffer u_zbuf (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .frag(frag),
        .frag_valid(frag_valid),
        .rd_addr(rd_addr),
        .rd_depth(rd_depth)
    );

endmodule

`default_nettype wire

/* rasterizer.sv */
`default_nettype none

module rasterizer (
    input wire clk,
    input wire rst,
    input wire start,
    input wire raster_pkg::triangle_t triangle,
    input wire raster_pkg::bbox_t box,
    input wire box_valid,
    input wire raster_pkg::recip_t recip,
    input wire div_done,
    output logic div_start,
    output raster_pkg::coord_t area,
    output raster_pkg::fragment_t frag,
    output logic frag_valid,
    output logic busy,
    output logic done
);
    import raster_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        VERIFY,
        INIT,
        WAIT_RECIP,
        WEIGHTS,
        ZINIT,
        DRAW,
        FINISH
    } state_t;

    state_t state;

    // e(a, b, p) = (px - ax) * (by - ay) - (py - ay) * (bx - ax), inside when all are > 0
    function automatic coord_t edge_fn(input coord_t ax, input coord_t ay, input coord_t bx,
                                       input coord_t by, input coord_t px, input coord_t py);
        logic signed [31:0] acc;
        acc = (px - ax) * (by - ay) - (py - ay) * (bx - ax);
        return coord_t'(acc);
    endfunction

    // Accumulator carries RECIP_FRAC fraction bits, rounding is folded into ZINIT
    function automatic depth_t z_to_depth(input zacc_t zv);
        zacc_t q;
        q = zv >>> RECIP_FRAC;
        if (q < 0) begin
            return '0;
        end
        if (q > zacc_t'(DEPTH_FAR)) begin
            return DEPTH_FAR;
        end
        return depth_t'(q);
    endfunction

    vertex_t v0;
    vertex_t v1;
    vertex_t v2;
    coord_t area_now;
    coord_t e0_c;
    coord_t e1_c;
    coord_t e2_c;
    coord_t x;
    coord_t y;
    coord_t e0;
    coord_t e1;
    coord_t e2;
    coord_t e0_row;
    coord_t e1_row;
    coord_t e2_row;
    coord_t e0_dx;
    coord_t e0_dy;
    coord_t e1_dx;
    coord_t e1_dy;
    coord_t e2_dx;
    coord_t e2_dy;
    fb_addr_t addr;
    fb_addr_t row_addr;
    weight_t recip_s;
    weight_t wa;
    weight_t wb;
    weight_t wa_dx;
    weight_t wa_dy;
    weight_t wb_dx;
    weight_t wb_dy;
    zacc_t dz1;
    zacc_t dz2;
    zacc_t z;
    zacc_t z_row;
    zacc_t z_dx;
    zacc_t z_dy;
    logic row_end;
    logic last_row;
    logic covered;

    assign v0 = triangle.v0;
    assign v1 = triangle.v1;
    assign v2 = triangle.v2;

    assign area_now = edge_fn(v0.x, v0.y, v1.x, v1.y, v2.x, v2.y);
    assign e0_c = edge_fn(v0.x, v0.y, v1.x, v1.y, box.min_x, box.min_y);
    assign e1_c = edge_fn(v1.x, v1.y, v2.x, v2.y, box.min_x, box.min_y);
    assign e2_c = edge_fn(v2.x, v2.y, v0.x, v0.y, box.min_x, box.min_y);

    // Depth runs from z0 along e2 (weight of v1) and e0 (weight of v2)
    assign dz1 = zacc_t'(v1.z) - zacc_t'(v0.z);
    assign dz2 = zacc_t'(v2.z) - zacc_t'(v0.z);
    assign recip_s = weight_t'({1'b0, recip});

    assign row_end = (x >= box.max_x);
    assign last_row = (y >= box.max_y);
    assign covered = (e0 > 0) && (e1 > 0) && (e2 > 0);

    assign busy = (state != IDLE) && (state != FINISH);
    assign done = (state == FINISH);
    assign div_start = (state == INIT);
    assign frag_valid = (state == DRAW) && covered;
    assign frag.addr = addr;
    assign frag.depth = z_to_depth(z);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= VERIFY;
                    end
                end
                VERIFY: begin
                    // Off-tile or back-facing triangles finish at once
                    if (box_valid && (area_now > 0)) begin
                        state <= INIT;
                    end else begin
                        state <= FINISH;
                    end
                end
                INIT: state <= WAIT_RECIP;
                WAIT_RECIP: begin
                    if (div_done) begin
                        state <= WEIGHTS;
                    end
                end
                WEIGHTS: state <= ZINIT;
                ZINIT: state <= DRAW;
                DRAW: begin
                    if (row_end && last_row) begin
                        state <= FINISH;
                    end
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            VERIFY: begin
                area <= area_now;
            end
            INIT: begin
                x <= box.min_x;
                y <= box.min_y;
                addr <= fb_addr_t'(box.min_y) * fb_addr_t'(TILE_W) + fb_addr_t'(box.min_x);
                row_addr <= fb_addr_t'(box.min_y) * fb_addr_t'(TILE_W) + fb_addr_t'(box.min_x);
                e0 <= e0_c;
                e1 <= e1_c;
                e2 <= e2_c;
                e0_row <= e0_c;
                e1_row <= e1_c;
                e2_row <= e2_c;
                e0_dx <= v1.y - v0.y;
                e0_dy <= v0.x - v1.x;
                e1_dx <= v2.y - v1.y;
                e1_dy <= v1.x - v2.x;
                e2_dx <= v0.y - v2.y;
                e2_dy <= v2.x - v0.x;
            end
            WEIGHTS: begin
                wa <= weight_t'(e2) * recip_s;
                wb <= weight_t'(e0) * recip_s;
                wa_dx <= weight_t'(e2_dx) * recip_s;
                wa_dy <= weight_t'(e2_dy) * recip_s;
                wb_dx <= weight_t'(e0_dx) * recip_s;
                wb_dy <= weight_t'(e0_dy) * recip_s;
            end
            ZINIT: begin
                z <= (zacc_t'(v0.z) <<< RECIP_FRAC) + (zacc_t'(1) <<< (RECIP_FRAC - 1))
                     + zacc_t'(wa) * dz1 + zacc_t'(wb) * dz2;
                z_row <= (zacc_t'(v0.z) <<< RECIP_FRAC) + (zacc_t'(1) <<< (RECIP_FRAC - 1))
                         + zacc_t'(wa) * dz1 + zacc_t'(wb) * dz2;
                z_dx <= zacc_t'(wa_dx) * dz1 + zacc_t'(wb_dx) * dz2;
                z_dy <= zacc_t'(wa_dy) * dz1 + zacc_t'(wb_dy) * dz2;
            end
            DRAW: begin
                if (!row_end) begin
                    x <= x + 1'b1;
                    addr <= addr + 1'b1;
                    e0 <= e0 + e0_dx;
                    e1 <= e1 + e1_dx;
                    e2 <= e2 + e2_dx;
                    z <= z + z_dx;
                end else if (!last_row) begin
                    // Next row restarts from the saved left edge
                    x <= box.min_x;
                    y <= y + 1'b1;
                    addr <= row_addr + fb_addr_t'(TILE_W);
                    row_addr <= row_addr + fb_addr_t'(TILE_W);
                    e0 <= e0_row + e0_dy;
                    e1 <= e1_row + e1_dy;
                    e2 <= e2_row + e2_dy;
                    e0_row <= e0_row + e0_dy;
                    e1_row <= e1_row + e1_dy;
                    e2_row <= e2_row + e2_dy;
                    z <= z_row + z_dy;
                    z_row <= z_row + z_dy;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* reciprocal_divider.sv */
`default_nettype none

module reciprocal_divider (
    input wire clk,
    input wire rst,
    input wire div_start,
    input wire raster_pkg::coord_t area,
    output raster_pkg::recip_t recip,
    output logic div_done
);
    import raster_pkg::*;

    div_word_t divisor;
    div_word_t rem;
    div_word_t quo;
    div_word_t rem_next;
    div_word_t quo_next;
    logic [$clog2(DIV_W)-1:0] count;
    logic running;

    // One restoring step; the start cycle already performs the first one
    always_comb begin
        div_word_t rem_src;
        div_word_t quo_src;
        div_word_t dvs_src;
        logic [DIV_W:0] partial;
        if (div_start) begin
            rem_src = '0;
            quo_src = DIV_DIVIDEND;
            dvs_src = div_word_t'(area);
        end else begin
            rem_src = rem;
            quo_src = quo;
            dvs_src = divisor;
        end
        partial = {rem_src, quo_src[DIV_W-1]};
        quo_next = {quo_src[DIV_W-2:0], 1'b0};
        if (partial >= {1'b0, dvs_src}) begin
            rem_next = div_word_t'(partial - {1'b0, dvs_src});
            quo_next[0] = 1'b1;
        end else begin
            rem_next = div_word_t'(partial);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            count <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                running <= 1'b1;
                count <= 1;
            end else if (running) begin
                count <= count + 1'b1;
                if (count == DIV_W - 1) begin
                    running <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor <= div_word_t'(area);
        end
        if (div_start || running) begin
            rem <= rem_next;
            quo <= quo_next;
        end
    end

    // An area of 1 gives 4096, which saturates
    assign recip = (|quo[DIV_W-1:RECIP_W]) ? '1 : quo[RECIP_W-1:0];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the rasterizer testbench with Verilator, runs it and checks the outcome
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f raster_top.f \
        --top-module raster_tb -o raster_sim \
    && ./obj_dir/raster_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && { echo "run passed"; exit 0; } \
    || { echo "run failed"; exit 1; }
